//--- verif/commBlockVectors.txt
# F: word count then frame words. M: payload word and index. R: reply word. H: memReady low cycles.
# E: addr cmd count packetErr addressed overflow, and it closes one test.
# good write of three words
F 6 2A01 0003 1234 ABCD 5A5A C9A1
M 1234 00
M ABCD 01
M 5A5A 02
E 2A 01 03 0 1 0
# bad checksum, the payload still streams
F 5 2A01 0002 1111 2222 FFFF
M 1111 00
M 2222 01
E 2A 01 02 1 1 0
# nonzero high byte in the count word
F 4 2A01 0101 7777 5C77
M 7777 00
E 2A 01 01 1 1 0
# short frame
F 4 2A01 0004 AAAA BBBB
M AAAA 00
M BBBB 01
E 2A 01 04 1 1 0
# long frame
F 5 2A01 0001 CCCC E6CC 1234
M CCCC 00
E 2A 01 01 1 1 0
# other address
F 5 3301 0002 1111 2222 0030
E 33 01 02 0 0 0
# status after one good and four bad packets
F 3 2A02 0000 2A02
R 0001
R 0004
E 2A 02 00 0 1 0
F 3 2A07 0000 2A07
E 2A 07 00 1 1 0
F 4 2A02 0001 5555 7F56
E 2A 02 01 1 1 0
F 3 2A02 0000 2A02
R 0002
R 0006
E 2A 02 00 0 1 0
# memReady held low across two frames
H 800
F 9 2A01 0006 0001 0002 0003 0004 0005 0006 2A00
F 9 2A01 0006 0001 0002 0003 0004 0005 0006 2A00
E 2A 01 06 0 1 1

//--- build.f
source/servProtPkg.sv
source/wordQueue.sv
source/spiReceiver.sv
source/servProtUnpacker.sv
source/statusInfo.sv
source/commBlock.sv
verif/commBlockTb.sv

//--- Makefile
TOP = commBlockTb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): build.f $(wildcard source/*.sv) verif/commBlockTb.sv
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f build.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/commBlockTb.sv
`default_nettype none

module commBlockTb;

	timeunit 1ns;
	timeprecision 100ps;

	import servProtPkg::*;

	logic         clk;
	logic         rst;
	logic         sclk;
	logic         csn;
	logic         mosi;
	logic         memReady = 1'b1;
	logic         replyReady = 1'b0;
	tMemWord      memData;
	logic         memValid;
	tPacketResult result;
	logic         overflow;
	tReplyWord    reply;
	logic         replyValid;

	string        tags[$];
	logic [31:0]  vals[$];
	int           frameLens[$];
	logic [15:0]  frameWords[$];
	tMemWord      expMem[$];
	tReplyWord    expReply[$];
	tMemWord      obsMem[$];
	tReplyWord    obsReply[$];
	tPacketResult obsRes[$];

	int           memBase = 0;
	int           replyBase = 0;
	int           resBase = 0;
	int           testNum = 0;
	int           testErrors = 0;
	int           testsFailed = 0;
	int           errors = 0;
	logic [15:0]  okModel = '0;
	logic [15:0]  errModel = '0;
	logic [31:0]  lfsr = 32'h491c_0c65;
	int unsigned  cycleCount = 0;
	int unsigned  holdUntil = 0;
	int unsigned  holdCycles = 0;
	int unsigned  totalBits = 0;
	int unsigned  limit = 32'hFFFF_FFFF;

	commBlock u_dut (
		.clk        (clk),
		.rst        (rst),
		.sclk       (sclk),
		.csn        (csn),
		.mosi       (mosi),
		.memData    (memData),
		.memValid   (memValid),
		.memReady   (memReady),
		.result     (result),
		.overflow   (overflow),
		.reply      (reply),
		.replyValid (replyValid),
		.replyReady (replyReady)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// galois form, shifting right.
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	always @(posedge clk) begin
		lfsr = lfsrStep(lfsr);
		replyReady <= lfsr[0];
		memReady   <= (cycleCount >= holdUntil);
	end

	always @(posedge clk) begin
		if (!rst) begin
			if (memValid && memReady) begin
				obsMem.push_back(memData);
			end
			if (replyValid && replyReady) begin
				obsReply.push_back(reply);
			end
			if (result.resultValid) begin
				obsRes.push_back(result);
			end
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= limit) begin
			$display("timeout: the run was still waiting after %0d cycles", cycleCount);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic tick(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s is %h, expected %h", name, got, exp);
			testErrors++;
		end
	endtask

	task automatic loadVectors();
		int          fd;
		int          code;
		int          nWords;
		string       tag;
		string       rest;
		logic [31:0] v;
		fd = $fopen("verif/commBlockVectors.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/commBlockVectors.txt");
			errors++;
			return;
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag[0] == "#") begin
				code = $fgets(rest, fd);
			end else begin
				tags.push_back(tag);
				case (tag)
					"F": nWords = -1;
					"H", "R": nWords = 1;
					"M": nWords = 2;
					"E": nWords = 6;
					default: begin
						$display("unknown record tag %s in the vector file", tag);
						errors++;
						nWords = 0;
					end
				endcase
				// a frame record carries its own word count first.
				if (nWords < 0) begin
					code = $fscanf(fd, "%h", v);
					if (code != 1) begin
						$display("frame record without a word count in the vector file");
						errors++;
						v = '0;
					end
					vals.push_back(v);
					nWords = v;
					totalBits += 16 * nWords;
				end
				repeat (nWords) begin
					code = $fscanf(fd, "%h", v);
					if (code != 1) begin
						$display("record %s is missing a field in the vector file", tag);
						errors++;
					end
					vals.push_back(v);
				end
			end
		end
		$fclose(fd);
	endtask

	// mode 0, so mosi changes while sclk is low.
	task automatic sendFrame(input int nWords);
		logic [15:0] word;
		if (holdCycles != 0) begin
			holdUntil <= cycleCount + holdCycles;
			holdCycles = 0;
		end
		csn <= 1'b0;
		repeat (nWords) begin
			word = frameWords.pop_front();
			for (int b = 15; b >= 0; b--) begin
				mosi <= word[b];
				tick(4);
				sclk <= 1'b1;
				tick(4);
				sclk <= 1'b0;
			end
		end
		tick(4);
		csn <= 1'b1;
		tick(8);
	endtask

	task automatic runTest();
		logic [31:0]  e [6];
		int           nFrames;
		tPacketResult res;
		for (int k = 0; k < 6; k++) begin
			e[k] = vals.pop_front();
		end
		testNum++;
		testErrors = 0;
		nFrames = frameLens.size();
		while (frameLens.size() > 0) begin
			sendFrame(frameLens.pop_front());
		end
		if (e[5] != 0) begin
			checkValue("overflow", 32'(overflow), 32'd1);
		end else begin
			while (obsRes.size() < resBase + nFrames) begin
				tick(1);
			end
			while (obsReply.size() < replyBase + expReply.size()) begin
				tick(1);
			end
			tick(16);
			assert (obsRes.size() == resBase + nFrames) else begin
				$display("test %0d: more result pulses than frames", testNum);
				testErrors++;
			end
			res = obsRes[resBase + nFrames - 1];
			checkValue("result.moduleAddr", 32'(res.moduleAddr), e[0]);
			checkValue("result.cmdCode", 32'(res.cmdCode), e[1]);
			checkValue("result.dataWordNum", 32'(res.dataWordNum), e[2]);
			checkValue("result.packetErr", 32'(res.packetErr), e[3]);
			checkValue("result.addressed", 32'(res.addressed), e[4]);
			checkValue("overflow", 32'(overflow), 32'd0);
			assert (obsMem.size() - memBase == expMem.size()) else begin
				$display("test %0d: %0d memory words seen, %0d expected",
					testNum, obsMem.size() - memBase, expMem.size());
				testErrors++;
			end
			for (int k = 0; k < expMem.size() && memBase + k < obsMem.size(); k++) begin
				checkValue("memData.data", 32'(obsMem[memBase + k].data), 32'(expMem[k].data));
				checkValue("memData.index", 32'(obsMem[memBase + k].index), 32'(expMem[k].index));
			end
			assert (obsReply.size() - replyBase == expReply.size()) else begin
				$display("test %0d: %0d reply words seen, %0d expected",
					testNum, obsReply.size() - replyBase, expReply.size());
				testErrors++;
			end
			for (int k = 0; k < expReply.size() && replyBase + k < obsReply.size(); k++) begin
				checkValue("reply", 32'(obsReply[replyBase + k]), 32'(expReply[k]));
			end
			// a status reply holds the counts from before the status packet itself.
			if (expReply.size() == 2) begin
				assert (expReply[0] == okModel && expReply[1] == errModel) else begin
					$display("test %0d: reply vectors disagree with the earlier packet counts",
						testNum);
					testErrors++;
				end
			end
			if (e[4] != 0) begin
				if (e[3] != 0) begin
					errModel = errModel + 1'b1;
				end else begin
					okModel = okModel + 1'b1;
				end
			end
		end
		memBase = obsMem.size();
		replyBase = obsReply.size();
		resBase = obsRes.size();
		expMem.delete();
		expReply.delete();
		if (testErrors != 0) begin
			testsFailed++;
		end
		errors += testErrors;
		$display("test %0d: %0d frame(s), %0d error(s)", testNum, nFrames, testErrors);
	endtask

	initial begin
		string       tag;
		logic [31:0] v;
		logic [31:0] w;
		int          n;
		tMemWord     mw;
		rst = 1'b1;
		sclk = 1'b0;
		csn = 1'b1;
		mosi = 1'b0;
		loadVectors();
		limit = totalBits * 8 + 2000;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		tick(4);
		while (tags.size() > 0) begin
			tag = tags.pop_front();
			case (tag)
				"H": holdCycles = vals.pop_front();
				"F": begin
					n = vals.pop_front();
					frameLens.push_back(n);
					repeat (n) begin
						v = vals.pop_front();
						frameWords.push_back(v[15:0]);
					end
				end
				"M": begin
					v = vals.pop_front();
					w = vals.pop_front();
					mw.data = v[15:0];
					mw.index = w[7:0];
					expMem.push_back(mw);
				end
				"R": begin
					v = vals.pop_front();
					expReply.push_back(v[15:0]);
				end
				"E": runTest();
				default: ;
			endcase
		end
		$display("%0d tests run, %0d failed, %0d errors", testNum, testsFailed, errors);
		if (errors == 0 && testNum > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/commBlock.sv
`default_nettype none

module commBlock #(
	parameter logic [7:0] blockAddr = 8'h2A
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      sclk,
	input  logic                      csn,
	input  logic                      mosi,
	output servProtPkg::tMemWord      memData,
	output logic                      memValid,
	input  logic                      memReady,
	output servProtPkg::tPacketResult result,
	output logic                      overflow,
	output servProtPkg::tReplyWord    reply,
	output logic                      replyValid,
	input  logic                      replyReady
);

	import servProtPkg::*;

	tSpiItem      spiItem;
	logic         spiItemValid;
	logic         spiItemReady;
	tSpiItem      queueItem;
	logic         queueItemValid;
	logic         queueItemReady;
	tPacketResult packetResult;
	tReplyWord    statusWord;
	logic         statusWordValid;
	logic         statusWordReady;

	assign result = packetResult;

	spiReceiver u_spiReceiver (
		.clk       (clk),
		.rst       (rst),
		.sclk      (sclk),
		.csn       (csn),
		.mosi      (mosi),
		.item      (spiItem),
		.itemValid (spiItemValid),
		.itemReady (spiItemReady),
		.overflow  (overflow)
	);

	wordQueue #(
		.tItem (tSpiItem),
		.depth (queueDepth)
	) u_spiQueue (
		.clk      (clk),
		.rst      (rst),
		.inData   (spiItem),
		.inValid  (spiItemValid),
		.inReady  (spiItemReady),
		.outData  (queueItem),
		.outValid (queueItemValid),
		.outReady (queueItemReady)
	);

	servProtUnpacker #(
		.blockAddr (blockAddr)
	) u_unpacker (
		.clk       (clk),
		.rst       (rst),
		.item      (queueItem),
		.itemValid (queueItemValid),
		.itemReady (queueItemReady),
		.memData   (memData),
		.memValid  (memValid),
		.memReady  (memReady),
		.result    (packetResult)
	);

	statusInfo u_statusInfo (
		.clk        (clk),
		.rst        (rst),
		.result     (packetResult),
		.reply      (statusWord),
		.replyValid (statusWordValid),
		.replyReady (statusWordReady)
	);

	wordQueue #(
		.tItem (tReplyWord),
		.depth (replyDepth)
	) u_replyQueue (
		.clk      (clk),
		.rst      (rst),
		.inData   (statusWord),
		.inValid  (statusWordValid),
		.inReady  (statusWordReady),
		.outData  (reply),
		.outValid (replyValid),
		.outReady (replyReady)
	);

endmodule

`default_nettype wire

//--- source/statusInfo.sv
`default_nettype none

module statusInfo (
	input  logic                      clk,
	input  logic                      rst,
	input  servProtPkg::tPacketResult result,
	output servProtPkg::tReplyWord    reply,
	output logic                      replyValid,
	input  logic                      replyReady
);

	import servProtPkg::*;

	typedef enum logic [1:0] {
		rsIdle,
		rsWord0,
		rsWord1
	} tReplyState;

	tReplyState           state;
	tPacketResult         lastRes;
	logic [wordWidth-1:0] okCount;
	logic [wordWidth-1:0] errCount;
	logic [wordWidth-1:0] snapOk;
	logic [wordWidth-1:0] snapErr;
	logic                 countIt;
	logic                 goodStatus;
	logic                 busyStatus;
	logic                 startReply;

	assign countIt    = lastRes.resultValid && lastRes.addressed;
	assign goodStatus = !lastRes.packetErr && (lastRes.cmdCode == cmdStatus);
	assign busyStatus = goodStatus && (state != rsIdle);
	assign startReply = countIt && goodStatus && (state == rsIdle);

	assign replyValid = (state != rsIdle);
	assign reply      = (state == rsWord1) ? snapErr : snapOk;

	always_ff @(posedge clk) begin
		if (rst) begin
			lastRes  <= '0;
			okCount  <= '0;
			errCount <= '0;
			state    <= rsIdle;
		end else begin
			lastRes <= result;

			if (countIt && !lastRes.packetErr && !busyStatus) begin
				if (okCount != '1) begin
					okCount <= okCount + 1'b1;
				end
			end
			// a status request that overlaps a reply in flight is refused.
			if (countIt && (lastRes.packetErr || busyStatus)) begin
				if (errCount != '1) begin
					errCount <= errCount + 1'b1;
				end
			end

			unique case (state)
				rsIdle:  if (startReply) state <= rsWord0;
				rsWord0: if (replyReady) state <= rsWord1;
				rsWord1: if (replyReady) state <= rsIdle;
				default: state <= rsIdle;
			endcase
		end
	end

	// the snapshot is taken before the status packet updates okCount.
	always_ff @(posedge clk) begin
		if (startReply) begin
			snapOk  <= okCount;
			snapErr <= errCount;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		(replyValid && !replyReady) |=> (replyValid && $stable(reply)))
		else $error("statusInfo changed a reply word that was not taken");

endmodule

`default_nettype wire

//--- source/servProtUnpacker.sv
`default_nettype none

module servProtUnpacker #(
	parameter logic [7:0] blockAddr = 8'h2A
) (
	input  logic                      clk,
	input  logic                      rst,
	input  servProtPkg::tSpiItem      item,
	input  logic                      itemValid,
	output logic                      itemReady,
	output servProtPkg::tMemWord      memData,
	output logic                      memValid,
	input  logic                      memReady,
	output servProtPkg::tPacketResult result
);

	import servProtPkg::*;

	typedef enum logic [2:0] {
		stHeader,
		stCount,
		stPayload,
		stChecksum,
		stDrain
	} tState;

	tState                state;
	logic [7:0]           addrReg;
	tCmdCode              cmdReg;
	logic [7:0]           cntReg;
	logic [7:0]           wordIdx;
	logic [wordWidth-1:0] xorAcc;
	logic                 errFlag;
	logic                 errOut;
	logic                 resValid;
	logic                 take;
	logic                 addressed;
	logic                 emit;
	logic                 cmdKnown;
	logic                 frameErr;

	// a pending memory word that is not taken stalls intake.
	// the cycle of a result pulse is also skipped, so two pulses never touch.
	assign itemReady = (!memValid || memReady) && !resValid;
	assign take      = itemValid && itemReady;

	assign addressed = (addrReg == blockAddr);
	assign emit      = addressed && (cmdReg == cmdWrite);
	assign cmdKnown  = (cmdReg == cmdWrite) || (cmdReg == cmdStatus);

	// a frame is only complete when the checksum has been seen, which leaves the FSM in stDrain.
	assign frameErr = errFlag || (state != stDrain) || !cmdKnown;

	assign result.moduleAddr  = addrReg;
	assign result.cmdCode     = cmdReg;
	assign result.dataWordNum = cntReg;
	assign result.packetErr   = errOut;
	assign result.addressed   = addressed;
	assign result.resultValid = resValid;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= stHeader;
			wordIdx  <= '0;
			errFlag  <= 1'b0;
			resValid <= 1'b0;
			memValid <= 1'b0;
		end else begin
			resValid <= 1'b0;
			if (memValid && memReady) begin
				memValid <= 1'b0;
			end

			if (take && item.endOfFrame) begin
				state    <= stHeader;
				errFlag  <= 1'b0;
				resValid <= 1'b1;
			end else if (take) begin
				unique case (state)
					stHeader: begin
						state <= stCount;
					end
					stCount: begin
						wordIdx <= '0;
						if (item.data[15:8] != 8'h00) begin
							errFlag <= 1'b1;
						end
						if (cmdReg == cmdStatus && item.data[7:0] != 8'h00) begin
							errFlag <= 1'b1;
						end
						state <= (item.data[7:0] == 8'h00) ? stChecksum : stPayload;
					end
					stPayload: begin
						if (emit) begin
							memValid <= 1'b1;
						end
						wordIdx <= wordIdx + 1'b1;
						if (wordIdx == cntReg - 8'd1) begin
							state <= stChecksum;
						end
					end
					stChecksum: begin
						if (item.data != xorAcc) begin
							errFlag <= 1'b1;
						end
						state <= stDrain;
					end
					stDrain: begin
						// anything after the checksum means the frame ran long.
						errFlag <= 1'b1;
					end
					default: begin
						state <= stHeader;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take && item.endOfFrame) begin
			errOut <= frameErr;
		end else if (take) begin
			unique case (state)
				stHeader: begin
					addrReg <= item.data[15:8];
					cmdReg  <= tCmdCode'(item.data[7:0]);
					xorAcc  <= item.data;
				end
				stCount: begin
					cntReg <= item.data[7:0];
					xorAcc <= xorAcc ^ item.data;
				end
				stPayload: begin
					xorAcc        <= xorAcc ^ item.data;
					memData.data  <= item.data;
					memData.index <= wordIdx;
				end
				default: begin
				end
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst) resValid |=> !resValid)
		else $error("servProtUnpacker resultValid held longer than one cycle");

endmodule

`default_nettype wire

//--- source/spiReceiver.sv
`default_nettype none

module spiReceiver (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 sclk,
	input  logic                 csn,
	input  logic                 mosi,
	output servProtPkg::tSpiItem item,
	output logic                 itemValid,
	input  logic                 itemReady,
	output logic                 overflow
);

	import servProtPkg::*;

	logic [1:0]                   sclkSync;
	logic [1:0]                   csnSync;
	logic [1:0]                   mosiSync;
	logic                         sclkPrev;
	logic                         csnPrev;
	logic                         sclkRise;
	logic                         csnRise;
	logic                         lastBit;
	logic [wordWidth-1:0]         shiftReg;
	logic [$clog2(wordWidth)-1:0] bitCnt;

	assign sclkRise = sclkSync[1] && !sclkPrev;
	assign csnRise  = csnSync[1] && !csnPrev;
	assign lastBit  = (bitCnt == ($clog2(wordWidth))'(wordWidth - 1));

	// mode 0 samples mosi on the rising sclk edge.
	// all three inputs see the same two flop delay, so data stays aligned with the edge.
	always_ff @(posedge clk) begin
		if (rst) begin
			sclkSync  <= '0;
			csnSync   <= '1;
			mosiSync  <= '0;
			sclkPrev  <= 1'b0;
			csnPrev   <= 1'b1;
			bitCnt    <= '0;
			itemValid <= 1'b0;
			overflow  <= 1'b0;
		end else begin
			sclkSync  <= {sclkSync[0], sclk};
			csnSync   <= {csnSync[0], csn};
			mosiSync  <= {mosiSync[0], mosi};
			sclkPrev  <= sclkSync[1];
			csnPrev   <= csnSync[1];
			itemValid <= 1'b0;

			// there is no way to hold an item back, so a refused push is lost for good.
			if (itemValid && !itemReady) begin
				overflow <= 1'b1;
			end

			if (csnSync[1]) begin
				bitCnt <= '0;
				if (csnRise) begin
					itemValid <= 1'b1;
				end
			end else if (sclkRise) begin
				bitCnt <= bitCnt + 1'b1;
				if (lastBit) begin
					itemValid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!csnSync[1] && sclkRise) begin
			shiftReg <= {shiftReg[wordWidth-2:0], mosiSync[1]};
			if (lastBit) begin
				item.data       <= {shiftReg[wordWidth-2:0], mosiSync[1]};
				item.endOfFrame <= 1'b0;
			end
		end else if (csnRise) begin
			// a partial word left in shiftReg is dropped here.
			item.data       <= '0;
			item.endOfFrame <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/wordQueue.sv
`default_nettype none

module wordQueue #(
	parameter type tItem = logic [15:0],
	parameter int  depth = 4
) (
	input  logic clk,
	input  logic rst,
	input  tItem inData,
	input  logic inValid,
	output logic inReady,
	output tItem outData,
	output logic outValid,
	input  logic outReady
);

	tItem mem [depth];

	logic [$clog2(depth)-1:0] wrPtr;
	logic [$clog2(depth)-1:0] rdPtr;
	logic [$clog2(depth):0]   count;
	logic                     push;
	logic                     pop;
	logic                     full;

	assign full     = (count == ($clog2(depth) + 1)'(depth));
	assign inReady  = !full;
	assign outValid = (count != '0);
	assign outData  = mem[rdPtr];

	assign push = inValid && inReady;
	assign pop  = outValid && outReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == ($clog2(depth))'(depth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == ($clog2(depth))'(depth - 1)) ? '0 : rdPtr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= inData;
		end
	end

	// a full queue that is not read stays full, so nothing was written over the oldest item.
	assert property (@(posedge clk) disable iff (rst)
		(full && !pop) |=> (full && rdPtr == $past(rdPtr) && wrPtr == $past(wrPtr)))
		else $error("wordQueue accepted a push while full");

endmodule

`default_nettype wire

//--- source/servProtPkg.sv
`default_nettype none

package servProtPkg;

	// size of one protocol word on the SPI link.
	localparam int wordWidth = 16;

	// depth of the queue between the SPI receiver and the unpacker.
	localparam int queueDepth = 8;

	// depth of the status reply queue.
	localparam int replyDepth = 4;

	// any code that is not listed here is unknown and flags the packet.
	typedef enum logic [7:0] {
		cmdWrite  = 8'h01,
		cmdStatus = 8'h02
	} tCmdCode;

	// one received word, or a frame end marker when endOfFrame is set.
	typedef struct packed {
		logic [wordWidth-1:0] data;
		logic                 endOfFrame;
	} tSpiItem;

	// payload word for the memory side with its position in the packet.
	typedef struct packed {
		logic [wordWidth-1:0] data;
		logic [7:0]           index;
	} tMemWord;

	// summary of one parsed packet.
	// resultValid is a single cycle pulse per frame.
	typedef struct packed {
		logic [7:0] moduleAddr;
		tCmdCode    cmdCode;
		logic [7:0] dataWordNum;
		logic       packetErr;
		logic       addressed;
		logic       resultValid;
	} tPacketResult;

	typedef logic [wordWidth-1:0] tReplyWord;

endpackage

`default_nettype wire
